// File: common/soc_pkg.sv
package soc_pkg;

	// Bus widths
	localparam int AXI_ADDR_WIDTH = 32;
	localparam int AXI_DATA_WIDTH = 32;
	localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

	typedef logic [AXI_ADDR_WIDTH-1:0] addr_t;   // Byte address
	typedef logic [AXI_DATA_WIDTH-1:0] data_t;
	typedef logic [AXI_STRB_WIDTH-1:0] strb_t;   // One bit per byte lane
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_DECERR = 2'b11;   // No slave at this address

	// Fabric defaults for the top level
	localparam int DEF_ENDPOINTS = 4;
	localparam int DEF_BANK_ADDR_WIDTH = 6;   // 64 words per bank

	// Address decoder FSM
	typedef enum logic {
		IDLE,
		WAIT_RESP
	} dec_state_t;

endpackage

// File: common/axi_lite_if.sv
`timescale 1ns/1ps

interface axi_lite_if;
	import soc_pkg::*;

	// Write address and data
	addr_t awaddr;
	logic awvalid;
	logic awready;
	data_t wdata;
	strb_t wstrb;
	logic wvalid;
	logic wready;

	// Write response
	resp_t bresp;
	logic bvalid;
	logic bready;

	// Read address and data
	addr_t araddr;
	logic arvalid;
	logic arready;
	data_t rdata;
	resp_t rresp;
	logic rvalid;
	logic rready;

	modport master (
		output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
		input awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);

	modport slave (
		input awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
		output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);

	// Request half of the master side
	modport req_src (
		output awaddr, awvalid, wdata, wstrb, wvalid, araddr, arvalid,
		input awready, wready, arready
	);

	modport rsp_sink (
		output bready, rready,
		input bresp, bvalid, rdata, rresp, rvalid
	);

endinterface

// File: design/bram_axi.sv
`timescale 1ns/1ps

module bram_axi #(
	parameter int BANK_ADDR_WIDTH = soc_pkg::DEF_BANK_ADDR_WIDTH
) (
	input logic clk_i,
	input logic reset_i,
	axi_lite_if.slave bus
);
	import soc_pkg::*;

	localparam int DEPTH = 2 ** BANK_ADDR_WIDTH;

	data_t mem [DEPTH];
	logic busy;
	logic wr_en;
	logic rd_en;
	logic [BANK_ADDR_WIDTH-1:0] wr_idx;
	logic [BANK_ADDR_WIDTH-1:0] rd_idx;
	logic bvalid_q;
	logic rvalid_q;
	data_t rdata_q;

	// Nothing new while a response is pending
	assign busy = bvalid_q || rvalid_q;
	assign wr_en = !busy && bus.awvalid && bus.wvalid;
	assign rd_en = !busy && bus.arvalid && !(bus.awvalid && bus.wvalid);

	assign bus.awready = wr_en;
	assign bus.wready = wr_en;
	assign bus.arready = rd_en;

	// Word index without the bank select bits
	assign wr_idx = bus.awaddr[BANK_ADDR_WIDTH+1:2];
	assign rd_idx = bus.araddr[BANK_ADDR_WIDTH+1:2];

	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			for (int i = 0; i < $bits(strb_t); i++) begin
				if (bus.wstrb[i]) begin
					mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
				end
			end
		end
		if (rd_en) begin
			rdata_q <= mem[rd_idx];
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_en) begin
				bvalid_q <= 1'b1;
			end else if (bus.bready) begin
				bvalid_q <= 1'b0;
			end
			if (rd_en) begin
				rvalid_q <= 1'b1;
			end else if (bus.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	assign bus.bvalid = bvalid_q;
	assign bus.bresp = RESP_OKAY;
	assign bus.rvalid = rvalid_q;
	assign bus.rdata = rdata_q;
	assign bus.rresp = RESP_OKAY;

endmodule

// File: crossbar/axi_addr_decoder.sv
`timescale 1ns/1ps

module axi_addr_decoder #(
	parameter int ENDPOINTS = soc_pkg::DEF_ENDPOINTS,
	parameter int BANK_ADDR_WIDTH = soc_pkg::DEF_BANK_ADDR_WIDTH,
	localparam int SEL_W = (ENDPOINTS > 1) ? $clog2(ENDPOINTS) : 1
) (
	input logic clk_i,
	input logic reset_i,
	input soc_pkg::addr_t awaddr_i,
	input logic awvalid_i,
	output logic awready_o,
	input soc_pkg::data_t wdata_i,
	input soc_pkg::strb_t wstrb_i,
	input logic wvalid_i,
	output logic wready_o,
	input soc_pkg::addr_t araddr_i,
	input logic arvalid_i,
	output logic arready_o,
	axi_lite_if.req_src bank_o [ENDPOINTS],
	input logic txn_done_i,
	output logic txn_busy_o,
	output logic txn_write_o,
	output logic [SEL_W-1:0] txn_sel_o,
	output logic txn_decerr_o
);
	import soc_pkg::*;

	localparam int OFFS_W = BANK_ADDR_WIDTH + 2;   // Byte offset bits inside one bank

	dec_state_t state;
	logic wr_take;
	logic rd_take;
	addr_t take_addr;
	addr_t take_idx;
	logic take_mapped;
	logic pend;   // Request still owed to the bank
	logic req_write;
	logic req_decerr;
	logic [SEL_W-1:0] req_sel;
	addr_t req_addr;
	data_t req_data;
	strb_t req_strb;
	logic [ENDPOINTS-1:0] aw_rdy;
	logic [ENDPOINTS-1:0] w_rdy;
	logic [ENDPOINTS-1:0] ar_rdy;
	logic bank_ack;

	// Write wins over a read in the same cycle
	assign wr_take = (state == IDLE) && awvalid_i && wvalid_i;
	assign rd_take = (state == IDLE) && arvalid_i && !(awvalid_i && wvalid_i);
	assign awready_o = wr_take;
	assign wready_o = wr_take;
	assign arready_o = rd_take;

	assign take_addr = wr_take ? awaddr_i : araddr_i;
	assign take_idx = take_addr >> OFFS_W;
	assign take_mapped = take_idx < addr_t'(ENDPOINTS);

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= IDLE;
			pend <= 1'b0;
			req_write <= 1'b0;
			req_decerr <= 1'b0;
			req_sel <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (wr_take || rd_take) begin
						state <= WAIT_RESP;
						pend <= take_mapped;   // Unmapped never reaches a bank
						req_write <= wr_take;
						req_decerr <= !take_mapped;
						req_sel <= take_idx[SEL_W-1:0];
					end
				end
				WAIT_RESP: begin
					if (bank_ack) pend <= 1'b0;
					if (txn_done_i) state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_take || rd_take) begin
			req_addr <= take_addr;
			req_data <= wdata_i;
			req_strb <= wstrb_i;
		end
	end

	for (genvar g = 0; g < ENDPOINTS; g++) begin : g_bank
		logic hit;
		assign hit = pend && (req_sel == SEL_W'(g));
		assign bank_o[g].awvalid = hit && req_write;
		assign bank_o[g].wvalid = hit && req_write;
		assign bank_o[g].arvalid = hit && !req_write;
		assign bank_o[g].awaddr = req_addr;
		assign bank_o[g].araddr = req_addr;
		assign bank_o[g].wdata = req_data;
		assign bank_o[g].wstrb = req_strb;
		assign aw_rdy[g] = bank_o[g].awready;
		assign w_rdy[g] = bank_o[g].wready;
		assign ar_rdy[g] = bank_o[g].arready;
	end

	assign bank_ack = pend && (req_write ? (aw_rdy[req_sel] && w_rdy[req_sel]) : ar_rdy[req_sel]);

	assign txn_busy_o = (state == WAIT_RESP);
	assign txn_write_o = req_write;
	assign txn_sel_o = req_sel;
	assign txn_decerr_o = req_decerr;

endmodule

// File: crossbar/axi_resp_mux.sv
`timescale 1ns/1ps

module axi_resp_mux #(
	parameter int ENDPOINTS = soc_pkg::DEF_ENDPOINTS,
	localparam int SEL_W = (ENDPOINTS > 1) ? $clog2(ENDPOINTS) : 1
) (
	input logic clk_i,
	input logic reset_i,
	axi_lite_if.rsp_sink bank_i [ENDPOINTS],
	input logic txn_busy_i,
	input logic txn_write_i,
	input logic [SEL_W-1:0] txn_sel_i,
	input logic txn_decerr_i,
	output soc_pkg::resp_t bresp_o,
	output logic bvalid_o,
	input logic bready_i,
	output soc_pkg::data_t rdata_o,
	output soc_pkg::resp_t rresp_o,
	output logic rvalid_o,
	input logic rready_i,
	output logic txn_done_o
);
	import soc_pkg::*;

	logic err_vld;   // Decode-error response on the bus
	logic bank_rsp;
	logic [ENDPOINTS-1:0] bvalid_v;
	logic [ENDPOINTS-1:0] rvalid_v;
	resp_t bresp_v [ENDPOINTS];
	resp_t rresp_v [ENDPOINTS];
	data_t rdata_v [ENDPOINTS];
	logic sel_bvalid;
	logic sel_rvalid;

	assign bank_rsp = txn_busy_i && !txn_decerr_i;

	for (genvar g = 0; g < ENDPOINTS; g++) begin : g_bank
		logic hit;
		assign hit = bank_rsp && (txn_sel_i == SEL_W'(g));
		assign bank_i[g].bready = hit && txn_write_i && bready_i;   // Only the owner sees ready
		assign bank_i[g].rready = hit && !txn_write_i && rready_i;
		assign bvalid_v[g] = bank_i[g].bvalid;
		assign rvalid_v[g] = bank_i[g].rvalid;
		assign bresp_v[g] = bank_i[g].bresp;
		assign rresp_v[g] = bank_i[g].rresp;
		assign rdata_v[g] = bank_i[g].rdata;
	end

	assign sel_bvalid = txn_decerr_i ? err_vld : bvalid_v[txn_sel_i];
	assign sel_rvalid = txn_decerr_i ? err_vld : rvalid_v[txn_sel_i];

	assign bvalid_o = txn_busy_i && txn_write_i && sel_bvalid;
	assign bresp_o = txn_decerr_i ? RESP_DECERR : bresp_v[txn_sel_i];
	assign rvalid_o = txn_busy_i && !txn_write_i && sel_rvalid;
	assign rresp_o = txn_decerr_i ? RESP_DECERR : rresp_v[txn_sel_i];
	assign rdata_o = txn_decerr_i ? '0 : rdata_v[txn_sel_i];

	assign txn_done_o = (bvalid_o && bready_i) || (rvalid_o && rready_i);

	// Raised the cycle after busy, dropped after the master takes it
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			err_vld <= 1'b0;
		end else if (txn_done_o) begin
			err_vld <= 1'b0;
		end else if (txn_busy_i && txn_decerr_i) begin
			err_vld <= 1'b1;
		end
	end

endmodule

// File: design/soc_top.sv
`timescale 1ns/1ps

module soc_top #(
	parameter int ENDPOINTS = soc_pkg::DEF_ENDPOINTS,
	parameter int BANK_ADDR_WIDTH = soc_pkg::DEF_BANK_ADDR_WIDTH
) (
	input logic clk_i,
	input logic reset_i,

	// Write address and data
	input soc_pkg::addr_t awaddr_i,
	input logic awvalid_i,
	output logic awready_o,
	input soc_pkg::data_t wdata_i,
	input soc_pkg::strb_t wstrb_i,
	input logic wvalid_i,
	output logic wready_o,

	output soc_pkg::resp_t bresp_o,
	output logic bvalid_o,
	input logic bready_i,

	// Read channels
	input soc_pkg::addr_t araddr_i,
	input logic arvalid_i,
	output logic arready_o,
	output soc_pkg::data_t rdata_o,
	output soc_pkg::resp_t rresp_o,
	output logic rvalid_o,
	input logic rready_i
);
	localparam int SEL_W = (ENDPOINTS > 1) ? $clog2(ENDPOINTS) : 1;

	logic txn_busy;
	logic txn_write;
	logic txn_decerr;
	logic txn_done;
	logic [SEL_W-1:0] txn_sel;

	axi_lite_if bank_if [ENDPOINTS] ();

	axi_addr_decoder #(
		.ENDPOINTS(ENDPOINTS),
		.BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
	) u_decoder (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.awaddr_i(awaddr_i),
		.awvalid_i(awvalid_i),
		.awready_o(awready_o),
		.wdata_i(wdata_i),
		.wstrb_i(wstrb_i),
		.wvalid_i(wvalid_i),
		.wready_o(wready_o),
		.araddr_i(araddr_i),
		.arvalid_i(arvalid_i),
		.arready_o(arready_o),
		.bank_o(bank_if),
		.txn_done_i(txn_done),
		.txn_busy_o(txn_busy),
		.txn_write_o(txn_write),
		.txn_sel_o(txn_sel),
		.txn_decerr_o(txn_decerr)
	);

	// One memory bank per address slot
	for (genvar g = 0; g < ENDPOINTS; g++) begin : g_bank
		bram_axi #(
			.BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
		) u_bram (
			.clk_i(clk_i),
			.reset_i(reset_i),
			.bus(bank_if[g])
		);
	end

	axi_resp_mux #(
		.ENDPOINTS(ENDPOINTS)
	) u_resp_mux (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.bank_i(bank_if),
		.txn_busy_i(txn_busy),
		.txn_write_i(txn_write),
		.txn_sel_i(txn_sel),
		.txn_decerr_i(txn_decerr),
		.bresp_o(bresp_o),
		.bvalid_o(bvalid_o),
		.bready_i(bready_i),
		.rdata_o(rdata_o),
		.rresp_o(rresp_o),
		.rvalid_o(rvalid_o),
		.rready_i(rready_i),
		.txn_done_o(txn_done)
	);

endmodule

// File: test/soc_sva.sv
`timescale 1ns/1ps

module soc_sva (
	input logic clk_i,
	input logic reset_i,
	input logic bvalid_i,
	input logic bready_i,
	input soc_pkg::resp_t bresp_i,
	input logic rvalid_i,
	input logic rready_i,
	input soc_pkg::data_t rdata_i,
	input soc_pkg::resp_t rresp_i
);

	int fail_count = 0;

	// No response may come out of reset
	assert property (@(posedge clk_i) reset_i |=> (!bvalid_i && !rvalid_i))
		else begin
			fail_count++;
			$error("A response valid was high right after reset");
		end

	assert property (@(posedge clk_i) disable iff (reset_i)
		(bvalid_i && !bready_i) |=> (bvalid_i && $stable(bresp_i)))
		else begin
			fail_count++;
			$error("Write response changed while bready was low");
		end

	assert property (@(posedge clk_i) disable iff (reset_i)
		(rvalid_i && !rready_i) |=> (rvalid_i && $stable(rdata_i) && $stable(rresp_i)))
		else begin
			fail_count++;
			$error("Read response changed while rready was low");
		end

endmodule

bind soc_top soc_sva u_soc_sva (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.bvalid_i(bvalid_o),
	.bready_i(bready_i),
	.bresp_i(bresp_o),
	.rvalid_i(rvalid_o),
	.rready_i(rready_i),
	.rdata_i(rdata_o),
	.rresp_i(rresp_o)
);

// File: test/tb_top.sv
`timescale 1ns/1ps

module tb_top;
	import soc_pkg::*;

	localparam string VEC_FILE = "test/golden_vectors.txt";
	localparam int CYCLES_PER_VEC = 60;

	logic clk;
	logic reset;
	addr_t awaddr;
	logic awvalid;
	logic awready;
	data_t wdata;
	strb_t wstrb;
	logic wvalid;
	logic wready;
	resp_t bresp;
	logic bvalid;
	logic bready;
	addr_t araddr;
	logic arvalid;
	logic arready;
	data_t rdata;
	resp_t rresp;
	logic rvalid;
	logic rready;

	// One entry per golden line
	bit vec_write [$];
	addr_t vec_addr [$];
	data_t vec_wdata [$];
	strb_t vec_strb [$];
	resp_t vec_resp [$];
	data_t vec_rdata [$];

	int cycle_count = 0;
	int cycle_limit = 0;   // Stays zero until the vectors are in

	soc_top u_soc_top (
		.clk_i(clk),
		.reset_i(reset),
		.awaddr_i(awaddr),
		.awvalid_i(awvalid),
		.awready_o(awready),
		.wdata_i(wdata),
		.wstrb_i(wstrb),
		.wvalid_i(wvalid),
		.wready_o(wready),
		.bresp_o(bresp),
		.bvalid_o(bvalid),
		.bready_i(bready),
		.araddr_i(araddr),
		.arvalid_i(arvalid),
		.arready_o(arready),
		.rdata_o(rdata),
		.rresp_o(rresp),
		.rvalid_o(rvalid),
		.rready_i(rready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: the vectors did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	task automatic check_value(input string name, input data_t actual, input data_t expected);
		if (actual !== expected) begin
			$display("Mismatch at time %0d ns: %s is %h, expected %h", $time, name, actual,
				expected);
			$display("Simulation failed");
			$fatal(1, "Stopped at the first wrong value");
		end
	endtask

	task automatic load_vectors();
		int fd;
		int n;
		string line;
		string op;
		addr_t addr;
		data_t wd;
		strb_t st;
		resp_t rs;
		data_t rd;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the vector file %s", VEC_FILE);
			$display("Simulation failed");
			$fatal(1, "No vectors");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") continue;   // Blank or column notes
			n = $sscanf(line, "%s %h %h %h %h %h", op, addr, wd, st, rs, rd);
			if (n != 6 || (op != "W" && op != "R")) begin
				$display("Vector line could not be read: %s", line);
				$display("Simulation failed");
				$fatal(1, "Bad vector file");
			end
			vec_write.push_back(op == "W");
			vec_addr.push_back(addr);
			vec_wdata.push_back(wd);
			vec_strb.push_back(st);
			vec_resp.push_back(rs);
			vec_rdata.push_back(rd);
		end
		$fclose(fd);
	endtask

	task automatic run_write(input addr_t addr, input data_t wd, input strb_t st,
			input resp_t exp_resp);
		int delay;
		awaddr <= addr;
		wdata <= wd;
		wstrb <= st;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do @(posedge clk); while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		delay = $urandom_range(0, 6);   // Hold off bready for a while
		repeat (delay) @(posedge clk);
		bready <= 1'b1;
		do @(posedge clk); while (!bvalid);
		bready <= 1'b0;
		check_value("bresp", 32'(bresp), 32'(exp_resp));
	endtask

	task automatic run_read(input addr_t addr, input resp_t exp_resp, input data_t exp_data);
		int delay;
		araddr <= addr;
		arvalid <= 1'b1;
		do @(posedge clk); while (!arready);
		arvalid <= 1'b0;
		delay = $urandom_range(0, 6);
		repeat (delay) @(posedge clk);
		rready <= 1'b1;
		do @(posedge clk); while (!rvalid);
		rready <= 1'b0;
		check_value("rresp", 32'(rresp), 32'(exp_resp));
		check_value("rdata", rdata, exp_data);
	endtask

	initial begin
		void'($urandom(62239));
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		load_vectors();
		if (vec_addr.size() == 0) begin
			$display("The vector file holds no transactions");
			$display("Simulation failed");
			$fatal(1, "Empty vector file");
		end
		cycle_limit = CYCLES_PER_VEC * vec_addr.size() + 20;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < vec_addr.size(); i++) begin
			repeat ($urandom_range(0, 3)) @(posedge clk);   // Idle gap
			if (vec_write[i]) begin
				run_write(vec_addr[i], vec_wdata[i], vec_strb[i], vec_resp[i]);
			end else begin
				run_read(vec_addr[i], vec_resp[i], vec_rdata[i]);
			end
		end
		repeat (2) @(posedge clk);
		if (u_soc_top.u_soc_sva.fail_count != 0) begin
			$display("A bound protocol assertion failed %0d times",
				u_soc_top.u_soc_sva.fail_count);
			$display("Simulation failed");
			$fatal(1, "Protocol assertion failures");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

// File: test/golden_vectors.txt
# op addr wdata strb resp rdata, everything after op in hex
# resp 0 is OKAY and 3 is DECERR, rdata is compared on reads only
W 00000000 11223344 f 0 00000000
R 00000000 00000000 0 0 11223344
W 00000104 a5a5a5a5 f 0 00000000
R 00000104 00000000 0 0 a5a5a5a5
W 00000208 cafef00d f 0 00000000
R 00000208 00000000 0 0 cafef00d
W 0000030c 0badc0de f 0 00000000
R 0000030c 00000000 0 0 0badc0de
W 000000fc 01020304 f 0 00000000
R 000000fc 00000000 0 0 01020304
R 00000003 00000000 0 0 11223344
W 00000104 ffffffff 1 0 00000000
R 00000104 00000000 0 0 a5a5a5ff
W 00000104 00000000 a 0 00000000
R 00000104 00000000 0 0 00a500ff
W 0000030c 12345678 6 0 00000000
R 0000030c 00000000 0 0 0b3456de
W 00000110 aaaa5555 f 0 00000000
W 00000210 12121212 f 0 00000000
R 00000110 00000000 0 0 aaaa5555
R 00000210 00000000 0 0 12121212
W 000003fc 5a5a5a5a f 0 00000000
W 00000400 ffffffff f 3 00000000
R 00000400 00000000 0 3 00000000
W fffffffc 87654321 f 3 00000000
R 80000000 00000000 0 3 00000000
R 00000000 00000000 0 0 11223344
R 000003fc 00000000 0 0 5a5a5a5a

// File: tb.f
common/soc_pkg.sv
common/axi_lite_if.sv
design/bram_axi.sv
crossbar/axi_addr_decoder.sv
crossbar/axi_resp_mux.sv
design/soc_top.sv
test/soc_sva.sv
test/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP := tb_top
FILELIST := tb.f
OBJ_DIR := obj_dir
PASS_MSG := Simulation passed

SIM := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
